//--- sources.f
rtl/if_pkg.sv
rtl/if_cfg_regs.sv
rtl/if_pc_select.sv
rtl/if_prefetch_buffer.sv
rtl/if_id_pipe.sv
rtl/if_stage_top.sv
dv/tb_if_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f sources.f --top-module tb_if_stage -o tb_if_stage \
  && ./obj_dir/tb_if_stage > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Test completed successfully" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- dv/tb_if_stage.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the instruction fetch stage
// APB driver, random-latency memory model and a PC reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_if_stage;

  import if_pkg::*;

  localparam int    Timeout    = 2000;
  localparam addr_t DataXor    = 32'hA5A5_0000;
  localparam addr_t DmHalt     = 32'h1A11_0800;
  localparam addr_t DmExc      = 32'h1A11_0808;

  logic        clk_i;
  logic        rst_ni;
  logic        req_i;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  cfg_addr_t   paddr_i;
  addr_t       pwdata_i;
  addr_t       prdata_o;
  logic        pready_o;
  logic        pslverr_o;
  instr_req_t  mem_req_o;
  instr_rsp_t  mem_rsp_i;
  logic        pc_set_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  irq_id_t     irq_id_i;
  addr_t       branch_target_i;
  logic        id_ready_i;
  logic        instr_valid_clear_i;
  logic        instr_valid_id_o;
  logic        instr_new_id_o;
  id_instr_t   id_instr_o;
  addr_t       pc_if_o;
  logic        if_busy_o;
  logic        pc_mismatch_alert_o;

  // scoreboard state
  logic [31:0] seed = 32'he498;
  int          errors;
  int          checks;
  int          tests;
  int          new_cnt;
  int          err_seen;
  int          cyc;
  int          ready_mode;
  addr_t       exp_pc;
  addr_t       redir_target;
  // fetch output address seen in the previous cycle
  addr_t       pc_if_prev;
  // register model
  addr_t       m_boot;
  addr_t       m_mtvec;
  addr_t       m_mtvecx;
  addr_t       m_mepc;
  addr_t       m_depc;
  // in-flight memory responses with the oldest at the front
  addr_t       pend_addr[$];
  int          pend_due[$];

  if_stage_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic in_err_region(input addr_t a);
    return (a >= 32'h0000_F000) && (a <= 32'h0000_FFFF);
  endfunction

  ////////////////////////////////////////////////////////////////////
  // compare tasks and report
  ////////////////////////////////////////////////////////////////////

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  task automatic check_instr(input string name, input instr_t got, input instr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s got %08h expected %08h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic test_done(input string name, input int err_before);
    tests++;
    $display("test %s : %s", name, (errors == err_before) ? "ok" : "errors found");
  endtask

  task automatic end_run();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////////////
  // memory model and decode ready
  ////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    logic [31:0] r;
    int          due;
    instr_rsp_t  rsp;
    cyc++;
    r = lcg_next();
    if (!rst_ni) begin
      mem_rsp_i  <= '0;
      id_ready_i <= 1'b0;
    end else begin
      rsp = '0;
      // a request stays outstanding up to and including its rvalid cycle
      check_bit("if_busy_o", if_busy_o, (pend_due.size() > 0) || mem_rsp_i.rvalid);
      if (mem_req_o.req) begin
        check_bit("mem_req_o.addr[1:0]==0", mem_req_o.addr[1:0] == 2'b00, 1'b1);
      end
      // handshake seen at this edge is answered 1 to 3 cycles later in order
      if (mem_req_o.req && mem_rsp_i.gnt) begin
        due = cyc + (int'(r[9:8]) % 3);
        if (pend_due.size() > 0 && due <= pend_due[$]) begin
          due = pend_due[$] + 1;
        end
        pend_addr.push_back(mem_req_o.addr);
        pend_due.push_back(due);
      end
      if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
        rsp.rvalid = 1'b1;
        rsp.rdata  = pend_addr[0] ^ DataXor;
        rsp.err    = in_err_region(pend_addr[0]);
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      rsp.gnt   = r[0] | r[1];
      mem_rsp_i <= rsp;
      case (ready_mode)
        0:       id_ready_i <= 1'b0;
        1:       id_ready_i <= 1'b1;
        default: id_ready_i <= r[4] | r[5];
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // reference model of the ID stream
  ////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      // an instruction accepted before a redirect still shows up here
      if (instr_new_id_o) begin
        check_addr("id_instr_o.pc", id_instr_o.pc, exp_pc);
        // the fetch output address during the accept cycle
        check_addr("pc_if_o", pc_if_prev, exp_pc);
        check_instr("id_instr_o.rdata", id_instr_o.rdata, exp_pc ^ DataXor);
        check_bit("id_instr_o.fetch_err", id_instr_o.fetch_err, in_err_region(exp_pc));
        if (id_instr_o.fetch_err) begin
          err_seen++;
        end
        exp_pc = exp_pc + 32'd4;
        new_cnt++;
      end
      if (pc_mismatch_alert_o) begin
        check_bit("pc_mismatch_alert_o", pc_mismatch_alert_o, 1'b0);
      end
      if (pc_set_i) begin
        exp_pc = redir_target;
      end
      pc_if_prev = pc_if_o;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // drivers
  ////////////////////////////////////////////////////////////////////

  task automatic apb_access(input logic wr, input cfg_addr_t a, input addr_t wdata,
                            output addr_t rdata, output logic slverr);
    int n;
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= wr;
    paddr_i   <= a;
    pwdata_i  <= wdata;
    @(posedge clk_i);
    penable_i <= 1'b1;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (!pready_o && n < Timeout);
    if (!pready_o) begin
      errors++;
      $display("timeout: APB access to offset %02h never completed", a);
      end_run();
    end else begin
      // zero wait states
      check_bit("pready_o in first access cycle", n == 1, 1'b1);
      rdata     = prdata_o;
      slverr    = pslverr_o;
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
      pwrite_i  <= 1'b0;
    end
  endtask

  task automatic apb_write(input cfg_addr_t a, input addr_t d);
    addr_t rd;
    logic  se;
    apb_access(1'b1, a, d, rd, se);
    check_bit("pslverr_o", se, 1'b0);
  endtask

  task automatic apb_read_check(input cfg_addr_t a, input addr_t exp, input logic exp_err);
    addr_t rd;
    logic  se;
    apb_access(1'b0, a, '0, rd, se);
    check_addr("prdata_o", rd, exp);
    check_bit("pslverr_o", se, exp_err);
  endtask

  task automatic redirect(input pc_sel_e sel, input exc_pc_sel_e esel, input irq_id_t id,
                          input addr_t tgt, input addr_t exp_target);
    @(posedge clk_i);
    redir_target = exp_target;
    pc_set_i        <= 1'b1;
    pc_mux_i        <= sel;
    exc_pc_mux_i    <= esel;
    irq_id_i        <= id;
    branch_target_i <= tgt;
    @(posedge clk_i);
    pc_set_i <= 1'b0;
  endtask

  task automatic wait_new(input int n, input string what);
    int target;
    int k;
    target = new_cnt + n;
    k = 0;
    while (new_cnt < target && k < Timeout) begin
      @(posedge clk_i);
      k++;
    end
    if (new_cnt < target) begin
      errors++;
      $display("timeout: no new ID instructions arrived during %s", what);
      end_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    int e0;
    rst_ni = 1'b0;
    req_i = 1'b0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    paddr_i = '0;
    pwdata_i = '0;
    mem_rsp_i = '0;
    pc_set_i = 1'b0;
    pc_mux_i = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXC;
    irq_id_i = '0;
    branch_target_i = '0;
    id_ready_i = 1'b0;
    instr_valid_clear_i = 1'b0;
    ready_mode = 1;
    exp_pc = '0;
    redir_target = '0;
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;

    // register access with alignment masks
    e0 = errors;
    apb_read_check(CFG_BOOT_OFFSET, 32'h0000_2000, 1'b0);
    m_boot   = 32'h0000_3400;
    m_mtvec  = 32'h0000_7700;
    m_mtvecx = 32'h5A5A_5A00;
    m_mepc   = 32'h0000_4000;
    m_depc   = 32'h0000_6004;
    apb_write(CFG_BOOT_OFFSET, 32'h0000_3456);
    apb_write(CFG_MTVEC_OFFSET, 32'h0000_7777);
    apb_write(CFG_MTVECX_OFFSET, 32'h5A5A_5A5F);
    apb_write(CFG_MEPC_OFFSET, 32'h0000_4003);
    apb_write(CFG_DEPC_OFFSET, 32'h0000_6006);
    apb_read_check(CFG_BOOT_OFFSET, m_boot, 1'b0);
    apb_read_check(CFG_MTVEC_OFFSET, m_mtvec, 1'b0);
    apb_read_check(CFG_MTVECX_OFFSET, m_mtvecx, 1'b0);
    apb_read_check(CFG_MEPC_OFFSET, m_mepc, 1'b0);
    apb_read_check(CFG_DEPC_OFFSET, m_depc, 1'b0);
    apb_read_check(8'h14, '0, 1'b1);
    test_done("registers", e0);

    // boot loads mtvec with the boot base
    e0 = errors;
    req_i <= 1'b1;
    redirect(PC_BOOT, EXC_PC_EXC, '0, '0, m_boot + BootOffset);
    m_mtvec = m_boot;
    wait_new(4, "boot");
    apb_read_check(CFG_MTVEC_OFFSET, m_mtvec, 1'b0);
    test_done("boot", e0);

    // sequential stream under random decode stalls
    e0 = errors;
    ready_mode = 2;
    wait_new(40, "sequential stream");
    test_done("sequential", e0);

    e0 = errors;
    redirect(PC_JUMP, EXC_PC_EXC, '0, 32'h0000_9000, 32'h0000_9000);
    wait_new(6, "jump");
    redirect(PC_EXC, EXC_PC_EXC, '0, '0, m_mtvec);
    wait_new(6, "exception");
    redirect(PC_EXC, EXC_PC_IRQ, 5'd5, '0, m_mtvec + 32'd20);
    wait_new(6, "interrupt");
    redirect(PC_EXC, EXC_PC_IRQ_X, 5'd3, '0, m_mtvecx + 32'd12);
    wait_new(6, "mtvecx interrupt");
    redirect(PC_ERET, EXC_PC_EXC, '0, '0, m_mepc);
    wait_new(6, "trap return");
    redirect(PC_DRET, EXC_PC_EXC, '0, '0, m_depc);
    wait_new(6, "debug return");
    redirect(PC_EXC, EXC_PC_DBD, '0, '0, DmHalt);
    wait_new(6, "debug entry");
    redirect(PC_EXC, EXC_PC_DBG_EXC, '0, '0, DmExc);
    wait_new(6, "debug exception");
    test_done("redirects", e0);

    // stream crosses out of the error region at 0x10000
    e0 = errors;
    err_seen = 0;
    redirect(PC_JUMP, EXC_PC_EXC, '0, 32'h0000_FFE0, 32'h0000_FFE0);
    wait_new(12, "fetch error");
    check_bit("fetch_err seen", err_seen != 0, 1'b1);
    test_done("fetch_error", e0);

    // decode stalls, then clears the held instruction
    e0 = errors;
    ready_mode = 0;
    repeat (4) @(posedge clk_i);
    repeat (6) begin
      @(posedge clk_i);
      check_bit("instr_valid_id_o", instr_valid_id_o, 1'b1);
      check_bit("instr_new_id_o", instr_new_id_o, 1'b0);
    end
    instr_valid_clear_i <= 1'b1;
    @(posedge clk_i);
    instr_valid_clear_i <= 1'b0;
    @(posedge clk_i);
    check_bit("instr_valid_id_o", instr_valid_id_o, 1'b0);
    test_done("valid_hold", e0);

    end_run();
  end

endmodule

//--- rtl/if_stage_top.sv
//////////////////////////////////////////////////////////////////////
// Instruction fetch stage
// config registers, PC mux, prefetch buffer and IF-ID register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module if_stage_top #(
  parameter if_pkg::addr_t DmHaltAddr      = 32'h1A11_0800,
  parameter if_pkg::addr_t DmExceptionAddr = 32'h1A11_0808,
  parameter if_pkg::addr_t BootAddrReset   = 32'h0000_2000,
  parameter bit            PcIncrCheck     = 1'b1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  // APB to the configuration registers
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  if_pkg::cfg_addr_t   paddr_i,
  input  if_pkg::addr_t       pwdata_i,
  output if_pkg::addr_t       prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  // instruction memory
  output if_pkg::instr_req_t  mem_req_o,
  input  if_pkg::instr_rsp_t  mem_rsp_i,
  // redirect control
  input  logic                pc_set_i,
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_pkg::irq_id_t     irq_id_i,
  input  if_pkg::addr_t       branch_target_i,
  // decode side
  input  logic                id_ready_i,
  input  logic                instr_valid_clear_i,
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output if_pkg::id_instr_t   id_instr_o,
  output if_pkg::addr_t       pc_if_o,
  output logic                if_busy_o,
  output logic                pc_mismatch_alert_o
);

  import if_pkg::*;

  cfg_regs_t  cfg;
  addr_t      fetch_addr_n;
  fetch_out_t fetch;

  if_cfg_regs #(
    .BootAddrReset (BootAddrReset)
  ) u_cfg_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .pc_set_i  (pc_set_i),
    .pc_mux_i  (pc_mux_i),
    .cfg_o     (cfg)
  );

  if_pc_select #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) u_pc_select (
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .irq_id_i        (irq_id_i),
    .branch_target_i (branch_target_i),
    .cfg_i           (cfg),
    .fetch_addr_o    (fetch_addr_n)
  );

  // every pc_set is a redirect of the fetch stream
  if_prefetch_buffer u_prefetch_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .branch_i      (pc_set_i),
    .branch_addr_i (fetch_addr_n),
    .ready_i       (id_ready_i),
    .fetch_o       (fetch),
    .mem_req_o     (mem_req_o),
    .mem_rsp_i     (mem_rsp_i),
    .busy_o        (if_busy_o)
  );

  if_id_pipe #(
    .PcIncrCheck (PcIncrCheck)
  ) u_id_pipe (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_i             (fetch),
    .id_ready_i          (id_ready_i),
    .pc_set_i            (pc_set_i),
    .branch_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .id_instr_o          (id_instr_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  assign pc_if_o = fetch.addr;

endmodule

//--- rtl/if_id_pipe.sv
//////////////////////////////////////////////////////////////////////
// IF-ID pipeline register
// valid/new flags for decode and the sequential-PC hardening check
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module if_id_pipe #(
  parameter bit PcIncrCheck = 1'b1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  if_pkg::fetch_out_t fetch_i,
  input  logic               id_ready_i,
  input  logic               pc_set_i,
  input  logic               branch_i,
  input  logic               instr_valid_clear_i,
  output logic               instr_valid_id_o,
  output logic               instr_new_id_o,
  output if_pkg::id_instr_t  id_instr_o,
  output logic               pc_mismatch_alert_o
);

  import if_pkg::*;

  logic accept;
  logic valid_d;

  // decode takes a word
  assign accept = fetch_i.valid & id_ready_i;

  // a word taken during a redirect is squashed, valid holds until cleared
  assign valid_d = (accept & ~pc_set_i) | (instr_valid_id_o & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= valid_d;
      instr_new_id_o   <= accept;
    end
  end

  // frozen while decode stalls
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_instr_o <= '{rdata: fetch_i.rdata, pc: fetch_i.addr, fetch_err: fetch_i.err};
    end
  end

  ////////////////////////////////////////////////////////////////////
  // sequential PC check
  ////////////////////////////////////////////////////////////////////

  if (PcIncrCheck) begin : g_pc_check
    addr_t pc_incr;
    logic  prev_seq_q;

    // any redirect breaks the sequence, so does reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        prev_seq_q <= 1'b0;
      end else begin
        prev_seq_q <= (prev_seq_q | accept) & ~branch_i;
      end
    end

    assign pc_incr = id_instr_o.pc + 32'd4;

    assign pc_mismatch_alert_o = prev_seq_q & fetch_i.valid & (fetch_i.addr != pc_incr);
  end else begin : g_no_pc_check
    assign pc_mismatch_alert_o = 1'b0;
  end

endmodule

//--- rtl/if_prefetch_buffer.sv
//////////////////////////////////////////////////////////////////////
// Prefetch buffer
// issues word fetches, tracks up to two outstanding requests and
// queues responses in a two-entry FIFO, flushing on redirect
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module if_prefetch_buffer (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_i,
  input  logic               branch_i,
  input  if_pkg::addr_t      branch_addr_i,
  input  logic               ready_i,
  output if_pkg::fetch_out_t fetch_o,
  output if_pkg::instr_req_t mem_req_o,
  input  if_pkg::instr_rsp_t mem_rsp_i,
  output logic               busy_o
);

  import if_pkg::*;

  typedef struct packed {
    instr_t rdata;
    addr_t  addr;
    logic   err;
  } fifo_entry_t;

  addr_t       fetch_addr_q, fetch_addr_d;
  addr_t       stale_addr_q;
  addr_t       branch_addr;
  addr_t       rsp_addr_q;
  logic        stale_q, stale_d;
  logic        req_held_q;
  logic        space;
  logic        gnt_fire;
  logic        rsp_take;
  logic [1:0]  outst_q, outst_d;
  logic [1:0]  discard_q, discard_d;
  logic [1:0]  cnt_q, cnt_d;
  logic [1:0]  cnt_kept;
  logic        pop;
  logic        pop_fifo;
  logic        push;
  fifo_entry_t fifo_q [2];
  fifo_entry_t fifo_d [2];
  fifo_entry_t in_entry;
  fifo_entry_t head;

  ////////////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////////////

  assign branch_addr = {branch_addr_i[31:2], 2'b00};
  // granted requests plus buffered words stay within the FIFO depth
  assign space       = (3'(outst_q) + 3'(cnt_q)) < 3'd2;

  // a request not yet granted is held, no new issue in a redirect cycle
  assign mem_req_o.req  = req_held_q | (req_i & space & ~branch_i);
  // a request pending across a redirect keeps its old address
  assign mem_req_o.addr = stale_q ? stale_addr_q : fetch_addr_q;
  assign gnt_fire       = mem_req_o.req & mem_rsp_i.gnt;

  assign stale_d = ~gnt_fire & (stale_q | (branch_i & mem_req_o.req));

  always_comb begin
    fetch_addr_d = fetch_addr_q;
    if (branch_i) begin
      fetch_addr_d = branch_addr;
    end else if (gnt_fire && !stale_q) begin
      fetch_addr_d = fetch_addr_q + 32'd4;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // outstanding and discard tracking
  ////////////////////////////////////////////////////////////////////

  assign outst_d = outst_q + 2'(gnt_fire) - 2'(mem_rsp_i.rvalid);

  // on redirect every response still in flight becomes stale, and so
  // does a held request once it gets its grant
  assign discard_d = (branch_i ? outst_q : discard_q)
                   + 2'(gnt_fire & (branch_i | stale_q))
                   - 2'(mem_rsp_i.rvalid & (branch_i | (discard_q != 2'd0)));

  assign rsp_take = mem_rsp_i.rvalid & ~branch_i & (discard_q == 2'd0);

  ////////////////////////////////////////////////////////////////////
  // instruction FIFO
  ////////////////////////////////////////////////////////////////////

  // responses arrive in order, so their address follows a running pointer
  assign in_entry = '{rdata: mem_rsp_i.rdata, addr: rsp_addr_q, err: mem_rsp_i.err};
  // empty FIFO passes the response straight through
  assign head     = (cnt_q != 2'd0) ? fifo_q[0] : in_entry;

  assign fetch_o.valid = ((cnt_q != 2'd0) | rsp_take) & ~branch_i;
  assign fetch_o.rdata = head.rdata;
  assign fetch_o.addr  = head.addr;
  assign fetch_o.err   = head.err;

  assign pop      = fetch_o.valid & ready_i;
  assign pop_fifo = pop & (cnt_q != 2'd0);
  assign push     = rsp_take & ~(pop & (cnt_q == 2'd0));
  assign cnt_kept = cnt_q - 2'(pop_fifo);

  always_comb begin
    fifo_d = fifo_q;
    if (pop_fifo) begin
      fifo_d[0] = fifo_q[1];
    end
    // a push only happens with at most one word left
    if (push) begin
      fifo_d[cnt_kept[0]] = in_entry;
    end
    cnt_d = branch_i ? 2'd0 : cnt_kept + 2'(push);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q <= '0;
      rsp_addr_q   <= '0;
      stale_q      <= 1'b0;
      req_held_q   <= 1'b0;
      outst_q      <= 2'd0;
      discard_q    <= 2'd0;
      cnt_q        <= 2'd0;
    end else begin
      fetch_addr_q <= fetch_addr_d;
      stale_q      <= stale_d;
      req_held_q   <= mem_req_o.req & ~mem_rsp_i.gnt;
      outst_q      <= outst_d;
      discard_q    <= discard_d;
      cnt_q        <= cnt_d;
      if (branch_i) begin
        rsp_addr_q <= branch_addr;
      end else if (rsp_take) begin
        rsp_addr_q <= rsp_addr_q + 32'd4;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (branch_i && mem_req_o.req && !mem_rsp_i.gnt) begin
      stale_addr_q <= mem_req_o.addr;
    end
    fifo_q <= fifo_d;
  end

  assign busy_o = (outst_q != 2'd0);

endmodule

//--- rtl/if_pc_select.sv
//////////////////////////////////////////////////////////////////////
// Next-PC selection
// picks the redirect target and the trap vector, purely combinational
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module if_pc_select #(
  parameter if_pkg::addr_t DmHaltAddr      = 32'h1A11_0800,
  parameter if_pkg::addr_t DmExceptionAddr = 32'h1A11_0808
) (
  input  if_pkg::pc_sel_e     pc_mux_i,
  input  if_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_pkg::irq_id_t     irq_id_i,
  input  if_pkg::addr_t       branch_target_i,
  input  if_pkg::cfg_regs_t   cfg_i,
  output if_pkg::addr_t       fetch_addr_o
);

  import if_pkg::*;

  addr_t irq_offset;
  addr_t exc_pc;
  addr_t boot_pc;

  // one 4-byte slot per interrupt line in vectored mode
  assign irq_offset = addr_t'({irq_id_i, 2'b00});
  // bases are already aligned in the register block
  assign boot_pc    = cfg_i.boot_addr + BootOffset;

  // trap vector
  always_comb begin
    case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = cfg_i.mtvec;
      EXC_PC_IRQ:     exc_pc = cfg_i.mtvec + irq_offset;
      EXC_PC_IRQ_X:   exc_pc = cfg_i.mtvecx + irq_offset;
      // debug entry and exceptions while in debug mode
      EXC_PC_DBD:     exc_pc = DmHaltAddr;
      EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:        exc_pc = cfg_i.mtvec;
    endcase
  end

  // fetch address
  always_comb begin
    case (pc_mux_i)
      PC_BOOT: fetch_addr_o = boot_pc;
      PC_JUMP: fetch_addr_o = branch_target_i;
      PC_EXC:  fetch_addr_o = exc_pc;
      // return from trap handler
      PC_ERET: fetch_addr_o = cfg_i.mepc;
      // return from debug mode
      PC_DRET: fetch_addr_o = cfg_i.depc;
      default: fetch_addr_o = boot_pc;
    endcase
  end

endmodule

//--- rtl/if_cfg_regs.sv
//////////////////////////////////////////////////////////////////////
// Fetch configuration registers
// APB slave holding boot base, trap vector bases and return PCs,
// mtvec is loaded from the boot base whenever the core boots
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module if_cfg_regs #(
  parameter if_pkg::addr_t BootAddrReset = 32'h0000_2000
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // APB slave, zero wait states
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  if_pkg::cfg_addr_t paddr_i,
  input  if_pkg::addr_t     pwdata_i,
  output if_pkg::addr_t     prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  // boot detection from the controller
  input  logic              pc_set_i,
  input  if_pkg::pc_sel_e   pc_mux_i,
  output if_pkg::cfg_regs_t cfg_o
);

  import if_pkg::*;

  // vector bases keep only the upper bits, return PCs are word aligned
  localparam addr_t VecMask  = {{($bits(addr_t) - VecAlignBits){1'b1}}, {VecAlignBits{1'b0}}};
  localparam addr_t WordMask = {{($bits(addr_t) - 2){1'b1}}, 2'b00};

  cfg_regs_t cfg_q, cfg_d;
  logic      apb_access;
  logic      addr_hit;
  logic      boot_init;

  // transfer completes in the access phase
  assign apb_access = psel_i & penable_i;
  assign boot_init  = pc_set_i & (pc_mux_i == PC_BOOT);

  ////////////////////////////////////////////////////////////////////
  // read decode
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    addr_hit = 1'b1;
    prdata_o = '0;
    case (paddr_i)
      CFG_BOOT_OFFSET:   prdata_o = cfg_q.boot_addr & VecMask;
      CFG_MTVEC_OFFSET:  prdata_o = cfg_q.mtvec & VecMask;
      CFG_MTVECX_OFFSET: prdata_o = cfg_q.mtvecx & VecMask;
      CFG_MEPC_OFFSET:   prdata_o = cfg_q.mepc & WordMask;
      CFG_DEPC_OFFSET:   prdata_o = cfg_q.depc & WordMask;
      // unmapped offset reads zero
      default:           addr_hit = 1'b0;
    endcase
  end

  assign pready_o  = 1'b1;
  assign pslverr_o = apb_access & ~addr_hit;

  ////////////////////////////////////////////////////////////////////
  // write decode
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    cfg_d = cfg_q;
    if (apb_access && pwrite_i) begin
      case (paddr_i)
        CFG_BOOT_OFFSET:   cfg_d.boot_addr = pwdata_i & VecMask;
        CFG_MTVEC_OFFSET:  cfg_d.mtvec     = pwdata_i & VecMask;
        CFG_MTVECX_OFFSET: cfg_d.mtvecx    = pwdata_i & VecMask;
        CFG_MEPC_OFFSET:   cfg_d.mepc      = pwdata_i & WordMask;
        CFG_DEPC_OFFSET:   cfg_d.depc      = pwdata_i & WordMask;
        default: ;
      endcase
    end
    // boot redirect points the exception vector at the boot base,
    // overriding a software write in the same cycle
    if (boot_init) begin
      cfg_d.mtvec = cfg_q.boot_addr & VecMask;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '{boot_addr: BootAddrReset & VecMask, default: '0};
    end else begin
      cfg_q <= cfg_d;
    end
  end

  assign cfg_o = cfg_q;

endmodule

//--- rtl/if_pkg.sv
//////////////////////////////////////////////////////////////////////
// Instruction fetch package
// widths, selector encodings and bundled interfaces of the fetch stage
//////////////////////////////////////////////////////////////////////

package if_pkg;

  // basic widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  irq_id_t;
  typedef logic [7:0]  cfg_addr_t;

  // next-PC source
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // trap vector source
  typedef enum logic [2:0] {
    EXC_PC_EXC     = 3'd0,
    EXC_PC_IRQ     = 3'd1,
    EXC_PC_IRQ_X   = 3'd2,
    EXC_PC_DBD     = 3'd3,
    EXC_PC_DBG_EXC = 3'd4
  } exc_pc_sel_e;

  // fetch request towards instruction memory
  typedef struct packed {
    logic  req;
    addr_t addr;
  } instr_req_t;

  // grant and response from instruction memory
  typedef struct packed {
    logic   gnt;
    logic   rvalid;
    instr_t rdata;
    logic   err;
  } instr_rsp_t;

  // head of the prefetch FIFO
  typedef struct packed {
    logic   valid;
    instr_t rdata;
    addr_t  addr;
    logic   err;
  } fetch_out_t;

  // registered instruction handed to decode
  typedef struct packed {
    instr_t rdata;
    addr_t  pc;
    logic   fetch_err;
  } id_instr_t;

  // configuration registers steering the PC mux
  typedef struct packed {
    addr_t boot_addr;
    addr_t mtvec;
    addr_t mtvecx;
    addr_t mepc;
    addr_t depc;
  } cfg_regs_t;

  // low bits cleared in boot base and vector bases
  localparam int unsigned VecAlignBits = 8;
  // first instruction sits this far above the boot base
  localparam addr_t       BootOffset   = 32'h0000_0080;

  // APB register map, byte offsets
  localparam cfg_addr_t CFG_BOOT_OFFSET   = 8'h00;
  localparam cfg_addr_t CFG_MTVEC_OFFSET  = 8'h04;
  localparam cfg_addr_t CFG_MTVECX_OFFSET = 8'h08;
  localparam cfg_addr_t CFG_MEPC_OFFSET   = 8'h0C;
  localparam cfg_addr_t CFG_DEPC_OFFSET   = 8'h10;

endpackage
